// File: clock_ctrl.sv
//////////////////////////////////////////////////
// Clock controller
// Mode, field and alarm enable state, and the
// steering of ticks, carries and presses
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module clock_ctrl (
	input  wire                clk,
	input  wire                rst_n,
	input  clock_pkg::btn_t    i_press,
	input  wire                i_sec_tick,
	input  clock_pkg::inc_t    i_carry,
	output clock_pkg::mode_e   o_mode,
	output clock_pkg::field_e  o_field,
	output logic               o_alarm_en,
	output clock_pkg::inc_t    o_time_inc,
	output clock_pkg::inc_t    o_alarm_inc
);

	clock_pkg::inc_t run_inc;
	clock_pkg::inc_t edit_inc;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_mode     <= clock_pkg::MODE_CLOCK;
			o_field    <= clock_pkg::FIELD_SEC;
			o_alarm_en <= 1'b0;
		end else begin
			if (i_press.mode) begin
				case (o_mode)
					clock_pkg::MODE_CLOCK: o_mode <= clock_pkg::MODE_SET;
					clock_pkg::MODE_SET:   o_mode <= clock_pkg::MODE_ALARM;
					default:               o_mode <= clock_pkg::MODE_CLOCK;
				endcase
			end
			if (i_press.field) begin
				case (o_field)
					clock_pkg::FIELD_SEC: o_field <= clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: o_field <= clock_pkg::FIELD_HOUR;
					default:              o_field <= clock_pkg::FIELD_SEC;
				endcase
			end
			if (i_press.alarm) begin
				o_alarm_en <= ~o_alarm_en;
			end
		end
	end

	// Free running count with the counter's own carries
	always_comb begin
		run_inc.sec  = i_sec_tick;
		run_inc.min  = i_carry.min;
		run_inc.hour = i_carry.hour;
	end

	// Inc press lands on the selected field only
	always_comb begin
		edit_inc = '0;
		case (o_field)
			clock_pkg::FIELD_SEC:  edit_inc.sec  = i_press.inc;
			clock_pkg::FIELD_MIN:  edit_inc.min  = i_press.inc;
			clock_pkg::FIELD_HOUR: edit_inc.hour = i_press.inc;
			default:               edit_inc      = '0;
		endcase
	end

	// Clock time is frozen in set mode, keeps running otherwise
	assign o_time_inc  = (o_mode == clock_pkg::MODE_SET) ? edit_inc : run_inc;
	assign o_alarm_inc = (o_mode == clock_pkg::MODE_ALARM) ? edit_inc : '0;

endmodule

`default_nettype wire

// File: clock_pkg.sv
//////////////////////////////////////////////////
// Digital clock shared definitions
// Mode and field encodings, time and pulse
// structs, field limits and segment patterns
//////////////////////////////////////////////////
`default_nettype none

package clock_pkg;

	// Display and edit mode
	typedef enum logic [1:0] {
		MODE_CLOCK = 2'd0,
		MODE_SET   = 2'd1,
		MODE_ALARM = 2'd2
	} mode_e;

	// Field selected for editing
	typedef enum logic [1:0] {
		FIELD_SEC  = 2'd0,
		FIELD_MIN  = 2'd1,
		FIELD_HOUR = 2'd2
	} field_e;

	typedef struct packed {
		logic [4:0] hour;
		logic [5:0] min;
		logic [5:0] sec;
	} hms_t;

	// One increment pulse per field
	typedef struct packed {
		logic sec;
		logic min;
		logic hour;
	} inc_t;

	// Push switches, as levels or as press pulses
	typedef struct packed {
		logic mode;
		logic field;
		logic inc;
		logic alarm;
	} btn_t;

	localparam int SEC_MAX  = 59;
	localparam int MIN_MAX  = 59;
	localparam int HOUR_MAX = 23;

	localparam int NUM_DIGITS = 6;

	// Segments a to g, a in the MSB, active high
	localparam int SEG_W = 7;
	typedef logic [SEG_W-1:0] seg_t;

	localparam seg_t SEG_PATTERNS [10] = '{
		7'b111_1110,
		7'b011_0000,
		7'b110_1101,
		7'b111_1001,
		7'b011_0011,
		7'b101_1011,
		7'b101_1111,
		7'b111_0000,
		7'b111_1111,
		7'b111_0011
	};

endpackage

`default_nettype wire

// File: digital_clock.sv
//////////////////////////////////////////////////
// Digital clock top level
// Timekeeping with alarm and a six-digit
// multiplexed seven-segment display
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module digital_clock #(
	parameter int TICK_DIV   = 50_000_000,
	parameter int SCAN_DIV   = 5_000,
	parameter int SAMPLE_DIV = 500_000
) (
	input  wire                               clk,
	input  wire                               rst_n,
	input  clock_pkg::btn_t                   i_sw,
	output clock_pkg::seg_t                   o_seg,
	output logic                              o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0]  o_seg_enb,
	output logic                              o_alarm
);

	logic              sec_tick;
	logic              scan_tick;
	logic              sample_tick;
	clock_pkg::btn_t   press;
	clock_pkg::mode_e  mode;
	clock_pkg::field_e field;
	logic              alarm_en;
	clock_pkg::inc_t   time_inc;
	clock_pkg::inc_t   alarm_inc;
	clock_pkg::inc_t   carry;
	clock_pkg::hms_t   disp_time;

	// One second
	tick_gen #(.DIV(TICK_DIV)) u_sec_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sec_tick)
	);

	// Digit scan rate
	tick_gen #(.DIV(SCAN_DIV)) u_scan_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (scan_tick)
	);

	// Switch sampling rate
	tick_gen #(.DIV(SAMPLE_DIV)) u_sample_tick (
		.clk    (clk),
		.rst_n  (rst_n),
		.o_tick (sample_tick)
	);

	switch_sync #(.SAMPLE_DIV(SAMPLE_DIV)) u_switch_sync (
		.clk      (clk),
		.rst_n    (rst_n),
		.i_sw     (i_sw),
		.i_sample (sample_tick),
		.o_press  (press)
	);

	clock_ctrl u_clock_ctrl (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_press     (press),
		.i_sec_tick  (sec_tick),
		.i_carry     (carry),
		.o_mode      (mode),
		.o_field     (field),
		.o_alarm_en  (alarm_en),
		.o_time_inc  (time_inc),
		.o_alarm_inc (alarm_inc)
	);

	timekeeper u_timekeeper (
		.clk         (clk),
		.rst_n       (rst_n),
		.i_time_inc  (time_inc),
		.i_alarm_inc (alarm_inc),
		.i_mode      (mode),
		.i_alarm_en  (alarm_en),
		.o_carry     (carry),
		.o_disp_time (disp_time),
		.o_alarm     (o_alarm)
	);

	seg_scan u_seg_scan (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_scan    (scan_tick),
		.i_time    (disp_time),
		.i_mode    (mode),
		.i_field   (field),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb)
	);

endmodule

`default_nettype wire

// File: digital_clock_properties.sv
//////////////////////////////////////////////////
// Digital clock assertions
// Scan enables, mode encoding, alarm flag and
// set mode steering, bound into the top level
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module digital_clock_properties (
	input wire                                clk,
	input wire                                rst_n,
	input wire [clock_pkg::NUM_DIGITS-1:0]    i_seg_enb,
	input clock_pkg::mode_e                   i_mode,
	input clock_pkg::field_e                  i_field,
	input wire                                i_alarm_en,
	input wire                                i_alarm,
	input clock_pkg::inc_t                    i_time_inc
);

	logic [2:0] sel_mask;

	// Bit of inc_t that belongs to the selected field
	always_comb begin
		case (i_field)
			clock_pkg::FIELD_SEC: sel_mask = 3'b100;
			clock_pkg::FIELD_MIN: sel_mask = 3'b010;
			default:              sel_mask = 3'b001;
		endcase
	end

	enb_one_hot: assert property (@(posedge clk) disable iff (!rst_n) $onehot(~i_seg_enb))
		else $error("digit enable not one-hot low");

	mode_legal: assert property (@(posedge clk) disable iff (!rst_n) i_mode != 2'd3)
		else $error("mode took the unused encoding");

	alarm_needs_en: assert property (@(posedge clk) disable iff (!rst_n)
		$rose(i_alarm) |-> $past(i_alarm_en))
		else $error("alarm rose while disabled");

	set_inc_selected: assert property (@(posedge clk) disable iff (!rst_n)
		(i_mode == clock_pkg::MODE_SET) |-> ((i_time_inc & ~sel_mask) == 3'b000))
		else $error("set mode increment on an unselected field");

endmodule

bind digital_clock digital_clock_properties u_props (
	.clk        (clk),
	.rst_n      (rst_n),
	.i_seg_enb  (o_seg_enb),
	.i_mode     (mode),
	.i_field    (field),
	.i_alarm_en (alarm_en),
	.i_alarm    (o_alarm),
	.i_time_inc (time_inc)
);

`default_nettype wire

// File: flist.f
clock_pkg.sv
tick_gen.sv
switch_sync.sv
clock_ctrl.sv
hms_counter.sv
timekeeper.sv
seg_scan.sv
digital_clock.sv
digital_clock_properties.sv
tb_digital_clock.sv

// File: hms_counter.sv
//////////////////////////////////////////////////
// Hours, minutes and seconds counter
// Independent per-field increments, each field
// wraps at its limit, with carry outputs
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module hms_counter (
	input  wire              clk,
	input  wire              rst_n,
	input  clock_pkg::inc_t  i_inc,
	output clock_pkg::hms_t  o_time,
	output clock_pkg::inc_t  o_carry
);

	logic sec_max;
	logic min_max;
	logic hour_max;

	assign sec_max  = (o_time.sec == 6'(clock_pkg::SEC_MAX));
	assign min_max  = (o_time.min == 6'(clock_pkg::MIN_MAX));
	assign hour_max = (o_time.hour == 5'(clock_pkg::HOUR_MAX));

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_time <= '0;
		end else begin
			if (i_inc.sec) begin
				o_time.sec <= sec_max ? 6'd0 : o_time.sec + 6'd1;
			end
			if (i_inc.min) begin
				o_time.min <= min_max ? 6'd0 : o_time.min + 6'd1;
			end
			if (i_inc.hour) begin
				o_time.hour <= hour_max ? 5'd0 : o_time.hour + 5'd1;
			end
		end
	end

	// Carries are combinational so a full rollover settles in one cycle
	assign o_carry = '{
		sec:  1'b0,
		min:  i_inc.sec & sec_max,
		hour: i_inc.min & min_max
	};

endmodule

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# Build and run the digital clock testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 \
	--top-module tb_digital_clock -o sim_digital_clock -f flist.f
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/sim_digital_clock)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "sim passed"; then
	exit 0
fi
exit 1

// File: seg_scan.sv
//////////////////////////////////////////////////
// Seven-segment display scan
// BCD split of the time, segment decode and
// digit multiplexing with decimal points
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module seg_scan (
	input  wire                                clk,
	input  wire                                rst_n,
	input  wire                                i_scan,
	input  clock_pkg::hms_t                    i_time,
	input  clock_pkg::mode_e                   i_mode,
	input  clock_pkg::field_e                  i_field,
	output clock_pkg::seg_t                    o_seg,
	output logic                               o_seg_dp,
	output logic [clock_pkg::NUM_DIGITS-1:0]   o_seg_enb
);

	localparam int IDX_W = $clog2(clock_pkg::NUM_DIGITS);
	localparam logic [IDX_W-1:0] IDX_LAST = IDX_W'(clock_pkg::NUM_DIGITS - 1);

	logic [IDX_W-1:0] digit_idx;
	logic [3:0]       digits [clock_pkg::NUM_DIGITS];
	logic [3:0]       cur_digit;

	// Two-digit value to {tens, ones}
	function automatic logic [7:0] to_bcd(input logic [5:0] value);
		logic [3:0] tens;
		logic [3:0] ones;
		tens = 4'(value / 6'd10);
		ones = 4'(value % 6'd10);
		return {tens, ones};
	endfunction

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			digit_idx <= '0;
		end else if (i_scan) begin
			if (digit_idx == IDX_LAST) begin
				digit_idx <= '0;
			end else begin
				digit_idx <= digit_idx + 1'b1;
			end
		end
	end

	// Digit 0 is the seconds ones, digit 5 the hours tens
	always_comb begin
		{digits[1], digits[0]} = to_bcd(i_time.sec);
		{digits[3], digits[2]} = to_bcd(i_time.min);
		{digits[5], digits[4]} = to_bcd({1'b0, i_time.hour});
	end

	assign cur_digit = digits[digit_idx];

	// Anything past 9 stays blank
	assign o_seg = (cur_digit < 4'd10) ? clock_pkg::SEG_PATTERNS[cur_digit] : '0;

	// Common node enables are active low
	assign o_seg_enb = ~(clock_pkg::NUM_DIGITS'(1) << digit_idx);

	always_comb begin
		if ((i_mode == clock_pkg::MODE_SET) || (i_mode == clock_pkg::MODE_ALARM)) begin
			// Mark the ones digit of the field being edited
			o_seg_dp = (digit_idx == IDX_W'({i_field, 1'b0}));
		end else begin
			o_seg_dp = ~digit_idx[0];
		end
	end

endmodule

`default_nettype wire

// File: switch_sync.sv
//////////////////////////////////////////////////
// Push switch conditioning
// Two-flop sync, periodic sampling and rising
// edge detect into one-cycle press pulses
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module switch_sync #(
	parameter int SAMPLE_DIV = 4
) (
	input  wire              clk,
	input  wire              rst_n,
	input  clock_pkg::btn_t  i_sw,
	input  wire              i_sample,
	output clock_pkg::btn_t  o_press
);

	// Ratio of one samples on every clock
	localparam bit SAMPLE_ALWAYS = (SAMPLE_DIV <= 1);

	clock_pkg::btn_t sw_meta;
	clock_pkg::btn_t sw_sync;
	clock_pkg::btn_t sw_level;
	logic            sample_en;

	assign sample_en = SAMPLE_ALWAYS | i_sample;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			sw_meta  <= '0;
			sw_sync  <= '0;
			sw_level <= '0;
			o_press  <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
			if (sample_en) begin
				sw_level <= sw_sync;
				// Sampled 0 to 1 change is a press
				o_press  <= clock_pkg::btn_t'(sw_sync & ~sw_level);
			end else begin
				o_press  <= '0;
			end
		end
	end

endmodule

`default_nettype wire

// File: tb_digital_clock.sv
//////////////////////////////////////////////////
// Digital clock testbench
// Seeded random presses, display decoding and a
// reference model of time, alarm and modes
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tb_digital_clock;

	localparam int TICK_DIV     = 96;
	localparam int SCAN_DIV     = 2;
	localparam int SAMPLE_DIV   = 4;
	localparam int CLK_PERIOD   = 40;
	localparam int PRESS_CYCLES = 3 * SAMPLE_DIV + 4;
	localparam int MID_WAIT     = 40;
	// Seconds each test may take
	localparam int TOTAL_SECONDS = 2 + 20 + 320 + 40 + 220;
	localparam int WATCHDOG_NS   = TOTAL_SECONDS * TICK_DIV * CLK_PERIOD + 100_000;

	localparam int PRESS_MODE  = 0;
	localparam int PRESS_FIELD = 1;
	localparam int PRESS_INC   = 2;
	localparam int PRESS_ALARM = 3;

	logic                                  clk;
	logic                                  rst_n;
	clock_pkg::btn_t                       sw;
	clock_pkg::seg_t                       o_seg;
	logic                                  o_seg_dp;
	logic [clock_pkg::NUM_DIGITS-1:0]      o_seg_enb;
	logic                                  o_alarm;

	// Reference model
	clock_pkg::hms_t   m_time;
	clock_pkg::hms_t   m_alarm;
	clock_pkg::mode_e  m_mode;
	clock_pkg::field_e m_field;
	logic              m_alarm_en;
	logic              m_alarm_flag;
	bit                counting;
	int                cyc;

	int test_errors;
	int total_errors;
	int tests_run;
	int tests_failed;

	digital_clock #(
		.TICK_DIV   (TICK_DIV),
		.SCAN_DIV   (SCAN_DIV),
		.SAMPLE_DIV (SAMPLE_DIV)
	) digital_clock_inst (
		.clk       (clk),
		.rst_n     (rst_n),
		.i_sw      (sw),
		.o_seg     (o_seg),
		.o_seg_dp  (o_seg_dp),
		.o_seg_enb (o_seg_enb),
		.o_alarm   (o_alarm)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	function automatic int to_secs(input clock_pkg::hms_t t);
		return int'(t.hour) * 3600 + int'(t.min) * 60 + int'(t.sec);
	endfunction

	function automatic clock_pkg::hms_t from_secs(input int s);
		clock_pkg::hms_t t;
		s = s % 86400;
		t.hour = 5'(s / 3600);
		t.min  = 6'((s / 60) % 60);
		t.sec  = 6'(s % 60);
		return t;
	endfunction

	// Edit increments wrap within the field, no carry
	function automatic clock_pkg::hms_t bump_field(input clock_pkg::hms_t t,
			input clock_pkg::field_e f);
		case (f)
			clock_pkg::FIELD_SEC:  t.sec  = (t.sec == 6'd59) ? 6'd0 : t.sec + 6'd1;
			clock_pkg::FIELD_MIN:  t.min  = (t.min == 6'd59) ? 6'd0 : t.min + 6'd1;
			default:               t.hour = (t.hour == 5'd23) ? 5'd0 : t.hour + 5'd1;
		endcase
		return t;
	endfunction

	function automatic int field_value(input clock_pkg::hms_t t, input clock_pkg::field_e f);
		case (f)
			clock_pkg::FIELD_SEC: return int'(t.sec);
			clock_pkg::FIELD_MIN: return int'(t.min);
			default:              return int'(t.hour);
		endcase
	endfunction

	function automatic logic [5:0] expected_dp(input clock_pkg::mode_e m,
			input clock_pkg::field_e f);
		if (m == clock_pkg::MODE_CLOCK) begin
			return 6'b010101;
		end
		return 6'b1 << (2 * int'(f));
	endfunction

	// Common segment encoding, a in the MSB
	function automatic logic [3:0] decode_seg(input logic [6:0] s);
		case (s)
			7'b1111110: return 4'd0;
			7'b0110000: return 4'd1;
			7'b1101101: return 4'd2;
			7'b1111001: return 4'd3;
			7'b0110011: return 4'd4;
			7'b1011011: return 4'd5;
			7'b1011111: return 4'd6;
			7'b1110000: return 4'd7;
			7'b1111111: return 4'd8;
			7'b1110011: return 4'd9;
			default:    return 4'hf;
		endcase
	endfunction

	// Seconds advance on every TICK_DIV-th rising edge after reset
	always @(posedge clk) begin
		if (counting) begin
			cyc = cyc + 1;
			if (((cyc % TICK_DIV) == 0) && (m_mode != clock_pkg::MODE_SET)) begin
				m_time = from_secs(to_secs(m_time) + 1);
			end
			// Alarm sets on a match and holds while enabled
			m_alarm_flag = m_alarm_en & (m_alarm_flag | (m_time == m_alarm));
		end
	end

	// Returns on the falling edge right after a second tick
	task automatic wait_boundary();
		do begin
			@(negedge clk);
		end while ((cyc % TICK_DIV) != 0);
	endtask

	task automatic apply_press(input int which);
		case (which)
			PRESS_MODE: begin
				case (m_mode)
					clock_pkg::MODE_CLOCK: m_mode = clock_pkg::MODE_SET;
					clock_pkg::MODE_SET:   m_mode = clock_pkg::MODE_ALARM;
					default:               m_mode = clock_pkg::MODE_CLOCK;
				endcase
			end
			PRESS_FIELD: begin
				case (m_field)
					clock_pkg::FIELD_SEC: m_field = clock_pkg::FIELD_MIN;
					clock_pkg::FIELD_MIN: m_field = clock_pkg::FIELD_HOUR;
					default:              m_field = clock_pkg::FIELD_SEC;
				endcase
			end
			PRESS_INC: begin
				if (m_mode == clock_pkg::MODE_SET) begin
					m_time = bump_field(m_time, m_field);
				end else if (m_mode == clock_pkg::MODE_ALARM) begin
					m_alarm = bump_field(m_alarm, m_field);
				end
			end
			default: m_alarm_en = ~m_alarm_en;
		endcase
	endtask

	// Press and release fit inside one second
	task automatic press_switch(input int which);
		wait_boundary();
		case (which)
			PRESS_MODE:  sw.mode  = 1'b1;
			PRESS_FIELD: sw.field = 1'b1;
			PRESS_INC:   sw.inc   = 1'b1;
			default:     sw.alarm = 1'b1;
		endcase
		repeat (PRESS_CYCLES) @(negedge clk);
		sw = '0;
		repeat (PRESS_CYCLES) @(negedge clk);
		apply_press(which);
	endtask

	task automatic read_display(output clock_pkg::hms_t t, output logic [5:0] dp);
		logic [3:0] d [6];
		for (int i = 0; i < 6; i++) begin
			while (o_seg_enb != ~(6'b1 << i)) begin
				@(negedge clk);
			end
			d[i]  = decode_seg(o_seg);
			dp[i] = o_seg_dp;
			@(negedge clk);
		end
		t.sec  = 6'(int'(d[1]) * 10 + int'(d[0]));
		t.min  = 6'(int'(d[3]) * 10 + int'(d[2]));
		t.hour = 5'(int'(d[5]) * 10 + int'(d[4]));
	endtask

	task automatic compare_display(input string what);
		clock_pkg::hms_t got;
		clock_pkg::hms_t exp_t;
		logic [5:0]      got_dp;
		logic [5:0]      exp_dp;
		exp_t  = (m_mode == clock_pkg::MODE_ALARM) ? m_alarm : m_time;
		exp_dp = expected_dp(m_mode, m_field);
		read_display(got, got_dp);
		if (got != exp_t) begin
			$display("[ERROR] %0t: %s shows %0d:%0d:%0d, expected %0d:%0d:%0d", $time, what,
				got.hour, got.min, got.sec, exp_t.hour, exp_t.min, exp_t.sec);
			test_errors++;
		end
		if (got_dp != exp_dp) begin
			$display("[ERROR] %0t: %s decimal points %b, expected %b", $time, what,
				got_dp, exp_dp);
			test_errors++;
		end
	endtask

	// Reads in the middle of the next second
	task automatic check_display(input string what);
		wait_boundary();
		repeat (MID_WAIT) @(negedge clk);
		compare_display(what);
	endtask

	task automatic check_alarm(input string what);
		wait_boundary();
		repeat (MID_WAIT) @(negedge clk);
		if (o_alarm !== m_alarm_flag) begin
			$display("[ERROR] %0t: %s o_alarm %b, expected %b", $time, what, o_alarm,
				m_alarm_flag);
			test_errors++;
		end
	endtask

	task automatic set_field(input clock_pkg::field_e f, input int target);
		int lim;
		int cur;
		while (m_field != f) begin
			press_switch(PRESS_FIELD);
		end
		lim = (f == clock_pkg::FIELD_HOUR) ? 24 : 60;
		cur = field_value((m_mode == clock_pkg::MODE_ALARM) ? m_alarm : m_time, f);
		repeat ((target - cur + lim) % lim) press_switch(PRESS_INC);
	endtask

	task automatic random_edits(input int n, input string what);
		repeat (n) begin
			if ($urandom_range(0, 2) == 0) begin
				press_switch(PRESS_FIELD);
			end else begin
				press_switch(PRESS_INC);
			end
			check_display(what);
		end
	endtask

	task automatic end_test(input string name);
		tests_run++;
		if (test_errors == 0) begin
			$display("Test %0d %s: PASS", tests_run, name);
		end else begin
			$display("Test %0d %s: FAIL with %0d errors", tests_run, name, test_errors);
			tests_failed++;
		end
		total_errors += test_errors;
		test_errors = 0;
	endtask

	initial begin
		#(WATCHDOG_NS);
		$display("Timeout: the tests did not finish within %0d ns", WATCHDOG_NS);
		$display("sim failed");
		$finish;
	end

	initial begin
		clock_pkg::hms_t target;
		int              guard;
		void'($urandom(32'hccf2_c617));
		sw           = '0;
		rst_n        = 1'b0;
		counting     = 1'b0;
		cyc          = 0;
		m_time       = '0;
		m_alarm      = '0;
		m_mode       = clock_pkg::MODE_CLOCK;
		m_field      = clock_pkg::FIELD_SEC;
		m_alarm_en   = 1'b0;
		m_alarm_flag = 1'b0;
		test_errors  = 0;
		total_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst_n    = 1'b1;
		counting = 1'b1;

		// Before the first tick
		repeat (4) @(negedge clk);
		compare_display("reset display");
		if (o_alarm !== 1'b0) begin
			$display("[ERROR] %0t: o_alarm %b after reset", $time, o_alarm);
			test_errors++;
		end
		end_test("reset");

		repeat ($urandom_range(5, 18)) wait_boundary();
		check_display("clock mode");
		end_test("timekeeping");

		press_switch(PRESS_MODE);
		check_display("set mode entry");
		random_edits(8, "set mode edit");
		repeat (2) wait_boundary();
		check_display("set mode frozen");
		set_field(clock_pkg::FIELD_SEC, 59);
		press_switch(PRESS_INC);
		check_display("seconds wrap");
		set_field(clock_pkg::FIELD_HOUR, 23);
		set_field(clock_pkg::FIELD_MIN, 59);
		set_field(clock_pkg::FIELD_SEC, 50 + $urandom_range(0, 5));
		check_display("set 23:59");
		press_switch(PRESS_MODE);
		press_switch(PRESS_MODE);
		repeat (8) wait_boundary();
		check_display("rollover");
		end_test("set mode");

		press_switch(PRESS_MODE);
		press_switch(PRESS_MODE);
		check_display("alarm mode entry");
		random_edits(6, "alarm mode edit");
		press_switch(PRESS_MODE);
		check_display("clock after alarm mode");
		end_test("alarm mode");

		press_switch(PRESS_MODE);
		press_switch(PRESS_MODE);
		// Far enough ahead to cover the edit presses
		target = from_secs(to_secs(m_time) + 180);
		set_field(clock_pkg::FIELD_HOUR, int'(target.hour));
		set_field(clock_pkg::FIELD_MIN, int'(target.min));
		set_field(clock_pkg::FIELD_SEC, int'(target.sec));
		press_switch(PRESS_MODE);
		press_switch(PRESS_ALARM);
		check_alarm("armed");
		guard = 0;
		while ((m_time != target) && (guard < 200)) begin
			wait_boundary();
			repeat (MID_WAIT) @(negedge clk);
			if ((m_time != target) && (o_alarm !== 1'b0)) begin
				$display("[ERROR] %0t: o_alarm high before the match", $time);
				test_errors++;
			end
			guard++;
		end
		if (m_time != target) begin
			$display("Alarm time was never reached by the clock");
			test_errors++;
		end
		check_alarm("after match");
		check_alarm("held");
		check_alarm("still held");
		press_switch(PRESS_ALARM);
		check_alarm("disabled");
		end_test("alarm flag");

		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed,
			total_errors);
		if (total_errors == 0) begin
			$display("sim passed");
		end else begin
			$display("sim failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: tick_gen.sv
//////////////////////////////////////////////////
// Tick generator
// One-cycle enable pulse every DIV clocks
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module tick_gen #(
	parameter int DIV = 2
) (
	input  wire  clk,
	input  wire  rst_n,
	output logic o_tick
);

	localparam int CNT_W = (DIV > 1) ? $clog2(DIV) : 1;
	localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(DIV - 1);

	logic [CNT_W-1:0] cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt <= '0;
		end else if (cnt == CNT_LAST) begin
			cnt <= '0;
		end else begin
			cnt <= cnt + 1'b1;
		end
	end

	// High during the last count of each period
	assign o_tick = (cnt == CNT_LAST);

endmodule

`default_nettype wire

// File: timekeeper.sv
//////////////////////////////////////////////////
// Timekeeper
// Clock and alarm counters, alarm match flag
// and selection of the displayed time
//////////////////////////////////////////////////
`timescale 1ns/1ns
`default_nettype none

module timekeeper (
	input  wire               clk,
	input  wire               rst_n,
	input  clock_pkg::inc_t   i_time_inc,
	input  clock_pkg::inc_t   i_alarm_inc,
	input  clock_pkg::mode_e  i_mode,
	input  wire               i_alarm_en,
	output clock_pkg::inc_t   o_carry,
	output clock_pkg::hms_t   o_disp_time,
	output logic              o_alarm
);

	clock_pkg::hms_t clock_time;
	clock_pkg::hms_t alarm_time;
	logic            time_match;

	hms_counter u_clock_time (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_inc   (i_time_inc),
		.o_time  (clock_time),
		.o_carry (o_carry)
	);

	// Alarm fields are edited one at a time, carries not needed
	hms_counter u_alarm_time (
		.clk     (clk),
		.rst_n   (rst_n),
		.i_inc   (i_alarm_inc),
		.o_time  (alarm_time),
		.o_carry ()
	);

	assign time_match = (clock_time == alarm_time);

	// Set on a match, held until the alarm is disabled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			o_alarm <= 1'b0;
		end else begin
			o_alarm <= i_alarm_en & (time_match | o_alarm);
		end
	end

	assign o_disp_time = (i_mode == clock_pkg::MODE_ALARM) ? alarm_time : clock_time;

endmodule

`default_nettype wire
